/* sim.f */
source/proc_pkg.sv
source/proc_cmddec.sv
source/proc_rf_lane.sv
source/proc_idb_drain.sv
source/proc_rfile.sv
bench/proc_rfile_props.sv
bench/tb_proc_rfile.sv

/* Bender.yml */
# Scratch register file path with its testbench
package:
  name: proc_rfile

sources:
  # RTL in compile order, package first
  - files:
      - source/proc_pkg.sv
      - source/proc_cmddec.sv
      - source/proc_rf_lane.sv
      - source/proc_idb_drain.sv
      - source/proc_rfile.sv

  # Bound assertions and the testbench top
  - target: simulation
    files:
      - bench/proc_rfile_props.sv
      - bench/tb_proc_rfile.sv

/* bench/tb_proc_rfile.sv */
// Testbench for proc_rfile; directed and xorshift random RF traffic checked against a model array
`default_nettype none
`timescale 1ns/1ns

module tb_proc_rfile;

  import proc_pkg::*;

  localparam int          N_OPS   = 760;             // 128 + 8 + 16 + 8 + 600 microwords
  localparam int          TIMEOUT = 4 * N_OPS + 500;  // Cycle limit for the whole run
  localparam logic [31:0] SEED    = 32'd36106;

  logic             sysclk;     // 100 ns clock
  logic             rst_n;
  microword_t       mw;
  logic             mw_valid;
  logic             mw_ready;
  logic [IDB_W-1:0] res_data;
  logic             res_valid;
  logic             res_ready;

  logic [IDB_W-1:0] model_mem [RF_DEPTH];  // Reference RAM with the whole word per address
  logic [IDB_W-1:0] exp_q [$];             // Expected results in issue order
  logic [31:0]      stim_state;            // Stimulus RNG
  logic [31:0]      ready_state;           // Separate RNG stream for the sink
  logic             rand_ready;            // Random back-pressure on/off
  int               results;               // Result handshakes seen
  int               mismatches;
  int               other_errs;
  int               cycles;

  proc_rfile #(
    .LANE_W (8)
  ) proc_rfile_i (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .mw        (mw),
    .mw_valid  (mw_valid),
    .mw_ready  (mw_ready),
    .res_data  (res_data),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  always #50 sysclk = ~sysclk;  // 100 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Odd multiplier keeps 0..63 distinct
  function automatic logic [RF_AW-1:0] pool_addr(input int i);
    return RF_AW'(i * 37 + 5);
  endfunction

  function automatic microword_t make_mw(input rf_op_e op, input logic [1:0] rf,
                                         input logic [3:0] lba, input logic [3:0] laa,
                                         input logic [IDB_W-1:0] data);
    microword_t w;
    w.op  = op;
    w.rf  = rf;
    w.lba = lba;
    w.laa = laa;
    w.idb = data;
    return w;
  endfunction

  // Reference model where the bank selects 256-word blocks and B the 16-word row
  function automatic void apply_ref(input microword_t w);
    int a;
    a = int'(w.rf) * 256 + int'(w.lba) * 16 + int'(w.laa);
    if (w.op == op_read || w.op == op_xchg) begin
      exp_q.push_back(model_mem[a]);  // Old word goes back on the IDB
    end
    if (w.op == op_write || w.op == op_xchg) begin
      model_mem[a] = w.idb;
    end
  endfunction

  // Caller sits on a falling edge; returns on the falling edge after the handshake
  task automatic send_mw(input microword_t w);
    mw       = w;
    mw_valid = 1'b1;
    do begin
      @(posedge sysclk);
    end while (!mw_ready);  // Pre-update value as the DUT sees it
    @(negedge sysclk);
    mw_valid = 1'b0;
  endtask

  task automatic send_at(input rf_op_e op, input logic [RF_AW-1:0] a,
                         input logic [IDB_W-1:0] data);
    send_mw(make_mw(op, a[9:8], a[7:4], a[3:0], data));
  endtask

  // All expected results taken, then a few idle cycles to catch strays
  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge sysclk);
    end
    repeat (4) @(negedge sysclk);
  endtask

  // Sink takes results at random or on every cycle
  always @(negedge sysclk) begin
    if (rand_ready) begin
      ready_state = xorshift32(ready_state);
      res_ready   = (ready_state[3:0] > 4'd4);  // Roughly 2 in 3 cycles
    end else begin
      res_ready = 1'b1;
    end
  end

  // Compare results, then feed the accepted microword to the model
  always @(posedge sysclk) begin : compare
    logic [IDB_W-1:0] exp_word;
    if (rst_n) begin
      if (res_valid && res_ready) begin
        results++;
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("Result %h arrived at %0t with no read or exchange outstanding",
                   res_data, $time);
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (res_data === exp_word) else begin
            mismatches++;
            $display("FAIL %0t: result %h, expected %h", $time, res_data, exp_word);
          end
        end
      end
      if (mw_valid && mw_ready) begin
        apply_ref(mw);
      end
    end
  end

  initial begin : watchdog
    while (cycles < TIMEOUT) begin
      @(posedge sysclk);
      cycles++;
    end
    $display("Run timed out after %0d cycles with %0d results still outstanding",
             cycles, exp_q.size());
    $display("Results %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             results, mismatches, other_errs, proc_rfile_i.cmddec.cmddec_props.fail_cnt);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    int               snap;
    int               gap;
    logic [31:0]      r;
    rf_op_e           op;
    sysclk      = 1'b0;
    rst_n       = 1'b0;
    mw          = '0;
    mw_valid    = 1'b0;
    res_ready   = 1'b1;
    rand_ready  = 1'b0;
    stim_state  = SEED;
    ready_state = ~SEED;
    results     = 0;
    mismatches  = 0;
    other_errs  = 0;
    cycles      = 0;
    repeat (16) @(negedge sysclk);
    rst_n = 1'b1;

    // Distinct words into 64 addresses, then read back
    for (int i = 0; i < 64; i++) begin
      send_at(op_write, pool_addr(i), IDB_W'(32'hC3A5 ^ (i * 32'h0101)));
    end
    for (int i = 0; i < 64; i++) begin
      send_at(op_read, pool_addr(i), '0);
    end
    wait_drained();

    // Exchange returns the old word and the read after it sees the new one
    for (int i = 0; i < 4; i++) begin
      send_at(op_xchg, pool_addr(i), IDB_W'(32'h5A00 + i));
      send_at(op_read, pool_addr(i), '0);
    end
    wait_drained();

    // Only the 4 reads and exchanges in this mix may return results
    snap = results;
    for (int k = 0; k < 16; k++) begin
      if (k % 2 == 0) begin
        op = op_nop;
      end else if (k == 3 || k == 11) begin
        op = op_read;
      end else if (k == 7 || k == 15) begin
        op = op_xchg;
      end else begin
        op = op_write;
      end
      send_at(op, pool_addr(10 + k), IDB_W'(32'h7700 + k));
    end
    wait_drained();
    assert (results - snap == 4) else begin
      other_errs++;
      $display("Expected 4 results from the no-op/write mix, got %0d", results - snap);
    end

    // One field changed at a time from the same base
    send_mw(make_mw(op_write, 2'd2, 4'd9, 4'd5, IDB_W'(32'h1111)));
    send_mw(make_mw(op_write, 2'd1, 4'd9, 4'd5, IDB_W'(32'h2222)));  // Bank differs
    send_mw(make_mw(op_write, 2'd2, 4'd6, 4'd5, IDB_W'(32'h3333)));  // B differs
    send_mw(make_mw(op_write, 2'd2, 4'd9, 4'd10, IDB_W'(32'h4444)));  // A differs
    send_mw(make_mw(op_read, 2'd2, 4'd9, 4'd5, '0));
    send_mw(make_mw(op_read, 2'd1, 4'd9, 4'd5, '0));
    send_mw(make_mw(op_read, 2'd2, 4'd6, 4'd5, '0));
    send_mw(make_mw(op_read, 2'd2, 4'd9, 4'd10, '0));
    wait_drained();

    // Random ops over the written pool with gaps and back-pressure
    rand_ready = 1'b1;
    for (int n = 0; n < 600; n++) begin
      stim_state = xorshift32(stim_state);
      r          = stim_state;
      gap        = r[4] ? int'(r[6:5]) : 0;  // Idle cycles before this word
      repeat (gap) @(negedge sysclk);
      send_at(rf_op_e'(r[1:0]), pool_addr(int'(r[13:8])), IDB_W'(r[31:16]));
    end
    rand_ready = 1'b0;
    wait_drained();

    $display("Results %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             results, mismatches, other_errs, proc_rfile_i.cmddec.cmddec_props.fail_cnt);
    if (mismatches == 0 && other_errs == 0 &&
        proc_rfile_i.cmddec.cmddec_props.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/proc_rfile_props.sv */
// Concurrent checks on the decoder handshake and reset, bound into every proc_cmddec instance
`default_nettype none
`timescale 1ns/1ns

module proc_rfile_props (
  input wire               sysclk,     // Decoder clock
  input wire               rst_n,      // Sync reset, active low
  input wire               mw_ready,   // Decoder ready towards the source
  input wire               advance,    // Pipe advance from the drain
  input proc_pkg::rf_cmd_t cmd,        // Stage 1 command
  input wire               cmd_valid   // Stage 1 valid
);

  int fail_cnt;  // Failed assertions so far

  initial fail_cnt = 0;

  // Ready stays shut on every edge that follows a reset edge
  a_ready_low_in_reset : assert property (
    @(posedge sysclk) !rst_n |=> !mw_ready
  ) else begin
    $error("mw_ready was high while the decoder was in reset");
    fail_cnt++;
  end

  // Stage 1 comes out of reset empty and stays empty one more cycle
  a_cmd_empty_after_reset : assert property (
    @(posedge sysclk) $rose(rst_n) |-> !cmd_valid ##1 !cmd_valid
  ) else begin
    $error("cmd_valid was high right after reset");
    fail_cnt++;
  end

  // Stalled command keeps its slot and its payload
  a_cmd_holds_on_stall : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    (cmd_valid && !advance) |=> (cmd_valid && $stable(cmd))
  ) else begin
    $error("Stage 1 command changed while the pipe was stalled");
    fail_cnt++;
  end

endmodule

// Attach to the decoder through its own signal names
bind proc_cmddec proc_rfile_props cmddec_props (
  .sysclk    (sysclk),
  .rst_n     (rst_n),
  .mw_ready  (mw_ready),
  .advance   (advance),
  .cmd       (cmd),
  .cmd_valid (cmd_valid)
);

`default_nettype wire

/* source/proc_rfile.sv */
// Top level of the scratch register file path; decoder, byte lanes and IDB drain in a 3-stage pipe
`default_nettype none
`timescale 1ns/1ns

module proc_rfile #(
  parameter int LANE_W = 8  // Lane width, 4, 8 or 16
) (
  input  wire                         sysclk,     // System clock
  input  wire                         rst_n,      // Sync reset, active low

  input  proc_pkg::microword_t        mw,         // Request microword
  input  wire                         mw_valid,   // Request present
  output logic                        mw_ready,   // Request taken

  output logic [proc_pkg::IDB_W-1:0]  res_data,   // Read or exchange result
  output logic                        res_valid,  // Result present
  input  wire                         res_ready   // Result taken
);

  import proc_pkg::*;

  localparam int LANES = IDB_W / LANE_W;  // Number of byte lanes, two at 16/8

  rf_cmd_t          cmd;                     // Stage 1 command
  logic             cmd_valid;               // Stage 1 valid
  logic             advance;                 // Pipe advance from the drain
  logic [IDB_W-1:0] lane_rdata;              // Lane read data, packed side by side
  logic             lane_valid [LANES];      // Per lane slot valid, lane 0 used
  rf_op_e           lane_op    [LANES];      // Per lane slot op, lane 0 used

  proc_cmddec cmddec (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .mw        (mw),
    .mw_valid  (mw_valid),
    .mw_ready  (mw_ready),
    .advance   (advance),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  // Identical RAM lanes, like the two RAM chips on the sheet
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    proc_rf_lane #(
      .LANE_W (LANE_W)
    ) lane (
      .sysclk     (sysclk),
      .rst_n      (rst_n),
      .advance    (advance),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .wdata      (cmd.wdata[i*LANE_W +: LANE_W]),   // This lane's byte
      .rdata      (lane_rdata[i*LANE_W +: LANE_W]),
      .slot_valid (lane_valid[i]),
      .slot_op    (lane_op[i])
    );
  end

  proc_idb_drain #(
    .LANE_W (LANE_W)
  ) drain (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .lane_rdata (lane_rdata),
    .slot_valid (lane_valid[0]),  // All lanes move in step
    .slot_op    (lane_op[0]),
    .res_data   (res_data),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .advance    (advance)
  );

endmodule

`default_nettype wire

/* source/proc_idb_drain.sv */
// IDB drain, stage 3; gathers lane read data into the result register and makes the advance
`default_nettype none
`timescale 1ns/1ns

module proc_idb_drain #(
  parameter int LANE_W = 8  // Lane width, must divide the IDB width
) (
  input  wire                         sysclk,      // System clock
  input  wire                         rst_n,       // Sync reset, active low

  input  wire  [proc_pkg::IDB_W-1:0]  lane_rdata,  // All lanes, lane 0 in the low bits
  input  wire                         slot_valid,  // Stage 2 slot occupied
  input  proc_pkg::rf_op_e            slot_op,     // Stage 2 op

  output logic [proc_pkg::IDB_W-1:0]  res_data,    // Result word on the IDB
  output logic                        res_valid,   // Result present
  input  wire                         res_ready,   // Sink takes it

  output logic                        advance      // Whole pipe moves this edge
);

  import proc_pkg::*;

  localparam int LANES = IDB_W / LANE_W;  // Lane count seen by the drain

  // Lanes must tile the bus exactly
  if (LANES * LANE_W != IDB_W) begin : g_lane_check
    $error("Lane width does not divide the IDB width");
  end

  logic             load;     // Slot carries a word for the IDB
  logic [IDB_W-1:0] data_q;   // Output register
  logic             valid_q;  // Output valid

  // Output register empty or draining, so everything behind may move
  assign advance = ~valid_q | res_ready;

  // Writes pass through stage 3 without a result
  assign load = advance & slot_valid & op_returns(slot_op);

  // Valid refills or clears on every advance, holds on back-pressure
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= load;
    end
  end

  // Lane slices land in place, per lane so the split stays visible
  for (genvar i = 0; i < LANES; i++) begin : g_slice
    always_ff @(posedge sysclk) begin
      if (load) begin
        data_q[i*LANE_W +: LANE_W] <= lane_rdata[i*LANE_W +: LANE_W];
      end
    end
  end

  assign res_data  = data_q;
  assign res_valid = valid_q;

endmodule

`default_nettype wire

/* source/proc_rf_lane.sv */
// One byte lane of the scratch register file; read-before-write RAM plus the stage 2 slot
`default_nettype none
`timescale 1ns/1ns

module proc_rf_lane #(
  parameter int LANE_W = 8  // Lane width, 4, 8 or 16
) (
  input  wire                     sysclk,      // System clock
  input  wire                     rst_n,       // Sync reset, active low

  input  wire                     advance,     // Pipeline moves this edge
  input  proc_pkg::rf_cmd_t       cmd,         // Stage 1 command, shared by all lanes
  input  wire                     cmd_valid,   // Stage 1 slot occupied
  input  wire  [LANE_W-1:0]       wdata,       // This lane's slice of the write data

  output logic [LANE_W-1:0]       rdata,       // Old word, registered
  output logic                    slot_valid,  // Stage 2 slot occupied
  output proc_pkg::rf_op_e        slot_op      // Op that produced the slot
);

  import proc_pkg::*;

  logic [LANE_W-1:0] mem [RF_DEPTH];  // Lane storage, contents undefined after reset
  logic              access;          // RAM cycle this edge
  logic              wr_en;           // Write part of the cycle
  logic [LANE_W-1:0] rdata_q;         // Read register
  logic              valid_q;         // Slot valid
  rf_op_e            op_q;            // Slot op

  assign access = advance & cmd_valid;
  assign wr_en  = access & op_writes(cmd.op);

  // Old word is sampled on the same edge the new one goes in
  always_ff @(posedge sysclk) begin
    if (access) begin
      rdata_q <= mem[cmd.addr];
    end
    if (wr_en) begin
      mem[cmd.addr] <= wdata;
    end
  end

  // Slot valid moves with the pipe
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= cmd_valid;
    end
  end

  // Op tag rides along with the read data
  always_ff @(posedge sysclk) begin
    if (access) begin
      op_q <= cmd.op;
    end
  end

  assign rdata      = rdata_q;
  assign slot_valid = valid_q;
  assign slot_op    = op_q;

endmodule

`default_nettype wire

/* source/proc_cmddec.sv */
// Microcommand decoder, stage 1 of the RF path; accepts microwords and registers RF commands
`default_nettype none
`timescale 1ns/1ns

module proc_cmddec (
  input  wire                  sysclk,     // System clock
  input  wire                  rst_n,      // Sync reset, active low

  input  proc_pkg::microword_t mw,         // Incoming microword
  input  wire                  mw_valid,   // Microword present
  output logic                 mw_ready,   // Decoder can take it

  input  wire                  advance,    // Pipeline moves this edge
  output proc_pkg::rf_cmd_t    cmd,        // Stage 1 command
  output logic                 cmd_valid   // Stage 1 slot occupied
);

  import proc_pkg::*;

  logic       rdy_q;      // Low through reset, high from first cycle after
  logic       accept;     // Handshake on this edge
  logic       keep;       // Accepted and not a no-op
  rf_cmd_t    cmd_next;   // Command built from the microword
  rf_cmd_t    cmd_q;      // Stage 1 payload
  logic       valid_q;    // Stage 1 valid

  // Ready gate, opens one cycle after rst_n goes high
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign mw_ready = advance & rdy_q;  // Only take words when stage 1 can move
  assign accept   = mw_valid & mw_ready;
  assign keep     = accept & (mw.op != op_nop);  // No-ops leave an empty slot

  // Address from bank, B and A fields; op and data pass as is
  always_comb begin
    cmd_next.op    = mw.op;
    cmd_next.addr  = rf_addr(mw);
    cmd_next.wdata = mw.idb;
  end

  // Stage 1 valid, empties when nothing useful comes in on an advance
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= keep;
    end
  end

  // Stage 1 payload, held under back-pressure
  always_ff @(posedge sysclk) begin
    if (keep) begin
      cmd_q <= cmd_next;
    end
  end

  assign cmd       = cmd_q;
  assign cmd_valid = valid_q;

endmodule

`default_nettype wire

/* source/proc_pkg.sv */
// Shared widths, register-file operation codes and microword/command structs for the RF path
`default_nettype none

package proc_pkg;

  // Internal data bus
  localparam int IDB_W = 16;  // IDB width, 8 and 32 also work

  // Register-file address fields, same split as the RF/LBA/LAA lines
  localparam int RF_BANK_W = 2;  // Bank select
  localparam int RF_LBA_W  = 4;  // B-address
  localparam int RF_LAA_W  = 4;  // A-address
  localparam int RF_AW     = RF_BANK_W + RF_LBA_W + RF_LAA_W;  // 10 bit word address
  localparam int RF_DEPTH  = 1 << RF_AW;  // 1024 words per lane

  // Register-file operation carried by the microword
  typedef enum logic [1:0] {
    op_nop   = 2'b00,  // Nothing, dropped at the decoder
    op_write = 2'b01,  // Write IDB data
    op_read  = 2'b10,  // Read onto IDB
    op_xchg  = 2'b11   // Return old word, write new one
  } rf_op_e;

  // Decoded microword as it arrives from the control store side
  typedef struct packed {
    rf_op_e               op;   // RF operation
    logic [RF_BANK_W-1:0] rf;   // Bank
    logic [RF_LBA_W-1:0]  lba;  // B-address
    logic [RF_LAA_W-1:0]  laa;  // A-address
    logic [IDB_W-1:0]     idb;  // Write data from IDB
  } microword_t;

  // Stage 1 command towards the RAM lanes
  typedef struct packed {
    rf_op_e           op;     // RF operation
    logic [RF_AW-1:0] addr;   // Full word address
    logic [IDB_W-1:0] wdata;  // Write data, all lanes
  } rf_cmd_t;

  // Word address as the sheet wires it: bank on top, then B, then A
  function automatic logic [RF_AW-1:0] rf_addr(microword_t w);
    rf_addr = {w.rf, w.lba, w.laa};
  endfunction

  // Ops that modify the RAM word
  function automatic logic op_writes(rf_op_e op);
    op_writes = (op == op_write) || (op == op_xchg);
  endfunction

  // Ops that put a word back on the IDB
  function automatic logic op_returns(rf_op_e op);
    op_returns = (op == op_read) || (op == op_xchg);
  endfunction

endpackage

`default_nettype wire
